/* Makefile */
# Verilator flow for the performance counter unit

VERILATOR  ?= verilator
TOP        ?= tb_perf_counter_unit
RTL_TOP    ?= perf_counter_unit
FILELIST   ?= perf_counter_unit.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation finished: PASS
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall

RTL_SRCS := hw/perf_pkg.sv \
            hw/perf_ctrl_if.sv \
            hw/perf_addr_decode.sv \
            hw/perf_counter_bank.sv \
            hw/perf_mmio_port.sv \
            hw/perf_counter_unit.sv
TB_SRCS  := tests/tb_perf_counter_unit.sv
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Lint the design on its own
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result, not the exit code of the run
sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/perf_addr_decode.sv */
// Address decoder turning an accepted access into a counter select and clear strobe
`default_nettype none

module perf_addr_decode (
  perf_ctrl_if.decoder ctrl
);
  import perf_pkg::*;

  logic clear_en;

  // Only an accepted store clears
  assign clear_en = ctrl.acc_fire && ctrl.acc_store;

  always_comb begin
    ctrl.sel   = '0;
    ctrl.clear = '0;
    // Odd and out-of-map addresses fall through with sel of 0
    for (int k = 0; k < num_counters; k++) begin
      if (ctrl.acc_addr == counter_addr(perf_event_e'(k))) begin
        ctrl.sel      = perf_sel_t'(k + 1);
        ctrl.clear[k] = clear_en;
      end
    end
  end

  // Clear checks, sampled whenever the decode settles
  always_comb begin
    a_clear_onehot0 : assert ($onehot0(ctrl.clear))
      else $error("perf_addr_decode: more than one clear bit set");
    a_clear_has_sel : assert ((ctrl.clear == '0) || (ctrl.sel != '0))
      else $error("perf_addr_decode: clear raised without a counter select");
  end

endmodule : perf_addr_decode

`default_nettype wire

/* hw/perf_counter_bank.sv */
// Bank of nine saturating 16-bit event counters with per-counter synchronous clear
`default_nettype none

module perf_counter_bank (
  input  logic                  clk,
  input  logic                  reset,
  input  perf_pkg::perf_event_t events,
  perf_ctrl_if.bank             ctrl
);
  import perf_pkg::*;

  perf_count_array_t count_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < num_counters; k++) begin
        count_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < num_counters; k++) begin
        // Clear beats an event in the same cycle
        if (ctrl.clear[k]) begin
          count_q[k] <= '0;
        end else if (events[k] && (count_q[k] != '1)) begin
          count_q[k] <= count_q[k] + 1'b1;
        end
      end
    end
  end

  assign ctrl.counts = count_q;

  // Without a clear a counter only holds or grows
  for (genvar g = 0; g < num_counters; g++) begin : g_no_decrease
    a_no_decrease : assert property (
      @(posedge clk) disable iff (reset)
      !ctrl.clear[g] |=> (count_q[g] >= $past(count_q[g]))
    ) else $error("perf_counter_bank: counter %0d decreased without a clear", g);
  end

endmodule : perf_counter_bank

`default_nettype wire

/* hw/perf_counter_unit.sv */
// Performance counter unit top level joining the MMIO port, decoder and counter bank
`default_nettype none

module perf_counter_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  perf_pkg::perf_event_t events,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  perf_pkg::perf_word_t  req_addr,
  input  logic                  req_store,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output perf_pkg::perf_word_t  rsp_data
);

  // Shared control bundle
  perf_ctrl_if ctrl_if ();

  // Bus handshake and read response
  perf_mmio_port i_perf_mmio_port (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .req_store (req_store),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .ctrl      (ctrl_if.port)
  );

  // Address map
  perf_addr_decode i_perf_addr_decode (
    .ctrl (ctrl_if.decoder)
  );

  // Event counters
  perf_counter_bank i_perf_counter_bank (
    .clk    (clk),
    .reset  (reset),
    .events (events),
    .ctrl   (ctrl_if.bank)
  );

endmodule : perf_counter_unit

`default_nettype wire

/* hw/perf_ctrl_if.sv */
// Control bundle linking the MMIO port, the address decoder and the counter bank
`default_nettype none

interface perf_ctrl_if;
  import perf_pkg::*;

  // Accepted request, valid for one cycle
  logic              acc_fire;
  perf_word_t        acc_addr;
  logic              acc_store;

  // Decode results
  perf_sel_t         sel;
  perf_clear_t       clear;

  // Live counter values
  perf_count_array_t counts;

  modport port (
    output acc_fire,
    output acc_addr,
    output acc_store,
    input  sel,
    input  counts
  );

  modport decoder (
    input  acc_fire,
    input  acc_addr,
    input  acc_store,
    output sel,
    output clear
  );

  modport bank (
    input  clear,
    output counts
  );

endinterface : perf_ctrl_if

`default_nettype wire

/* hw/perf_mmio_port.sv */
// MMIO request/response port with a one-entry registered read response
`default_nettype none

module perf_mmio_port (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  perf_pkg::perf_word_t req_addr,
  input  logic                 req_store,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output perf_pkg::perf_word_t rsp_data,
  perf_ctrl_if.port            ctrl
);
  import perf_pkg::*;

  logic       rsp_valid_q;
  perf_word_t rsp_data_q;
  perf_word_t read_value;
  logic       accept;
  logic       stalled;

  // Room for a new request when the response slot is empty or draining
  assign req_ready = !rsp_valid_q || rsp_ready;
  assign accept    = req_valid && req_ready;
  assign stalled   = rsp_valid_q && !rsp_ready;

  // Request fields go straight to the decoder
  assign ctrl.acc_fire  = accept;
  assign ctrl.acc_addr  = req_addr;
  assign ctrl.acc_store = req_store;

  // Read mux, zero for an unmapped address
  always_comb begin
    read_value = '0;
    for (int k = 0; k < num_counters; k++) begin
      if (ctrl.sel == perf_sel_t'(k + 1)) begin
        read_value = ctrl.counts[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Value before the accept edge, so a store returns the pre-clear count
  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data_q <= read_value;
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp_data  = rsp_data_q;

  // A stalled response keeps its data until it is taken
  a_rsp_stable : assert property (
    @(posedge clk) disable iff (reset)
    stalled |=> rsp_valid && $stable(rsp_data)
  ) else $error("perf_mmio_port: response changed while stalled");

  // No access reaches the decoder while a response is stalled
  a_no_accept_stalled : assert property (
    @(posedge clk) disable iff (reset)
    stalled |-> !req_ready && !ctrl.acc_fire
  ) else $error("perf_mmio_port: request accepted while response stalled");

endmodule : perf_mmio_port

`default_nettype wire

/* hw/perf_pkg.sv */
// Performance counter unit shared types, counter count and MMIO address map
`default_nettype none

package perf_pkg;

  // One machine word, used for addresses, counter values and read data
  typedef logic [15:0] perf_word_t;

  localparam int num_counters = 9;

  // One strobe per event, indexed by counter number
  typedef logic [num_counters-1:0] perf_event_t;

  // 0 means no counter, 1 to 9 select counters 0 to 8
  typedef logic [3:0] perf_sel_t;

  // One-hot or zero
  typedef logic [num_counters-1:0] perf_clear_t;

  typedef perf_word_t perf_count_array_t [num_counters];

  // Counter indices
  typedef enum logic [3:0] {
    l2_hit,
    l2_miss,
    dl1_hit,
    dl1_miss,
    il1_hit,
    il1_miss,
    br_predict,
    br_mispredict,
    stall_cycle
  } perf_event_e;

  // Counter 0 sits here, the rest step down by one word
  localparam perf_word_t perf_addr_base = 16'hfff0;

  function automatic perf_word_t counter_addr(perf_event_e ev);
    return perf_addr_base - (perf_word_t'(ev) << 1);
  endfunction

endpackage : perf_pkg

`default_nettype wire

/* perf_counter_unit.f */
hw/perf_pkg.sv
hw/perf_ctrl_if.sv
hw/perf_addr_decode.sv
hw/perf_counter_bank.sv
hw/perf_mmio_port.sv
hw/perf_counter_unit.sv
tests/tb_perf_counter_unit.sv

/* tests/tb_perf_counter_unit.sv */
// Testbench for the performance counter unit with a cycle-level reference model
`default_nettype none

module tb_perf_counter_unit;
  timeunit 1ns;
  timeprecision 1ps;

  import perf_pkg::*;

  localparam int wait_limit      = 200;
  localparam int saturate_cycles = 65540;

  logic        clk;
  logic        reset;
  perf_event_t events;
  logic        req_valid;
  logic        req_ready;
  perf_word_t  req_addr;
  logic        req_store;
  logic        rsp_valid;
  logic        rsp_ready;
  perf_word_t  rsp_data;

  // Stimulus knobs, only touched by the main process
  logic        random_events;
  logic        random_ready;
  perf_event_t event_hold;

  // Reference state
  perf_word_t  model_count [num_counters];
  perf_word_t  expected_q[$];
  int          req_count;
  int          rsp_count;
  perf_word_t  last_rsp_data;

  int          main_errors;
  int          cmp_errors;
  int          errors_before;

  perf_counter_unit i_perf_counter_unit (
    .clk       (clk),
    .reset     (reset),
    .events    (events),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .req_store (req_store),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Counters step down one word at a time from fff0
  function automatic perf_word_t counter_address(input int k);
    return 16'hfff0 - perf_word_t'(2 * k);
  endfunction

  // Counter index for an address, -1 when unmapped
  function automatic int addr_to_index(input perf_word_t addr);
    int offset;
    offset = 65520 - int'(addr);
    if (offset < 0 || offset > 16 || (offset % 2) != 0) begin
      return -1;
    end
    return offset / 2;
  endfunction

  // Read value seen at the accept edge, queued for the compare process
  function automatic perf_word_t expect_read(input perf_word_t addr);
    int         idx;
    perf_word_t value;
    idx   = addr_to_index(addr);
    value = (idx < 0) ? 16'h0000 : model_count[idx];
    expected_q.push_back(value);
    return value;
  endfunction

  task automatic check_value(input perf_word_t actual, input perf_word_t expected,
                             input string what, inout int errors);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // One clock edge, then next-cycle events and response back-pressure
  task automatic tick();
    @(posedge clk);
    events    <= random_events ? perf_event_t'($urandom) : event_hold;
    rsp_ready <= random_ready ? (($urandom & 32'h1) != 0) : 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) tick();
  endtask

  task automatic idle_bus();
    req_valid <= 1'b0;
  endtask

  // Leaves req_valid high so the next call can follow back to back
  task automatic send_request(input perf_word_t addr, input logic store);
    int waited;
    waited    = 0;
    req_valid <= 1'b1;
    req_addr  <= addr;
    req_store <= store;
    do begin
      tick();
      waited++;
      if (!req_ready && waited >= wait_limit) begin
        report_timeout("acceptance of a request");
      end
    end while (!req_ready);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    do begin
      tick();
      waited++;
      if (expected_q.size() != 0 && waited >= wait_limit) begin
        report_timeout("the response to every request");
      end
    end while (expected_q.size() != 0);
  endtask

  task automatic load_all();
    for (int j = 0; j < num_counters; j++) begin
      send_request(counter_address(j), 1'b0);
    end
    idle_bus();
  endtask

  task automatic finish_test(input string name);
    $display("test %s finished with %0d errors", name,
             main_errors + cmp_errors - errors_before);
    errors_before = main_errors + cmp_errors;
  endtask

  always @(posedge clk) begin : reference_model
    int clear_idx;
    if (reset) begin
      for (int k = 0; k < num_counters; k++) begin
        model_count[k] = '0;
      end
    end else begin
      clear_idx = -1;
      if (req_valid && req_ready) begin
        void'(expect_read(req_addr));
        req_count++;
        if (req_store) begin
          clear_idx = addr_to_index(req_addr);
        end
      end
      // Clear wins over an event, a full counter stays full
      for (int k = 0; k < num_counters; k++) begin
        if (k == clear_idx) begin
          model_count[k] = '0;
        end else if (events[k] && model_count[k] != 16'hffff) begin
          model_count[k] = model_count[k] + 16'd1;
        end
      end
    end
  end

  always @(posedge clk) begin : compare_responses
    perf_word_t exp_value;
    if (!reset && rsp_valid && rsp_ready) begin
      if (expected_q.size() == 0) begin
        $display("error at %0t: response arrived with no request outstanding", $time);
        cmp_errors++;
      end else begin
        exp_value = expected_q.pop_front();
        check_value(rsp_data, exp_value, "response data", cmp_errors);
        last_rsp_data = rsp_data;
        rsp_count++;
      end
    end
  end

  initial begin : run_tests
    perf_word_t addr;
    void'($urandom(32'h3601c0cf));
    reset         <= 1'b1;
    events        <= '0;
    req_valid     <= 1'b0;
    req_addr      <= '0;
    req_store     <= 1'b0;
    rsp_ready     <= 1'b1;
    random_events = 1'b0;
    random_ready  = 1'b0;
    event_hold    = '0;
    idle_cycles(8);
    reset <= 1'b0;
    tick();
    check_value(perf_word_t'(req_ready), 16'h0001, "req_ready after reset", main_errors);
    check_value(perf_word_t'(rsp_valid), 16'h0000, "rsp_valid after reset", main_errors);
    finish_test("reset");

    // Random events with loads spread over all nine counters
    random_events = 1'b1;
    for (int i = 0; i < 60; i++) begin
      send_request(counter_address(i % num_counters), 1'b0);
      idle_bus();
      idle_cycles($urandom_range(0, 5));
    end
    random_events = 1'b0;
    wait_drained();
    finish_test("counting");

    for (int k = 0; k < num_counters; k++) begin
      send_request(counter_address(k), 1'b1);
      idle_bus();
      // Cleared counter counts up again
      event_hold = perf_event_t'(1) << k;
      idle_cycles(3);
      event_hold = '0;
      load_all();
    end
    wait_drained();
    finish_test("store_clear");

    for (int i = 0; i < 24; i++) begin
      addr = perf_word_t'($urandom);
      if (addr_to_index(addr) >= 0) begin
        addr = addr ^ 16'h8000;
      end
      send_request(addr, i[0]);
    end
    // Odd words inside the map window
    for (perf_word_t a = 16'hffe1; a < 16'hfff0; a += 16'd2) begin
      send_request(a, a[1]);
    end
    load_all();
    wait_drained();
    finish_test("unmapped");

    event_hold = perf_event_t'(1) << stall_cycle;
    idle_cycles(saturate_cycles);
    event_hold = '0;
    tick();
    send_request(counter_address(stall_cycle), 1'b0);
    idle_bus();
    wait_drained();
    check_value(last_rsp_data, 16'hffff, "stall counter after saturation", main_errors);
    event_hold = perf_event_t'(1) << stall_cycle;
    tick();
    event_hold = '0;
    tick();
    send_request(counter_address(stall_cycle), 1'b0);
    idle_bus();
    wait_drained();
    check_value(last_rsp_data, 16'hffff, "stall counter after one more event", main_errors);
    finish_test("saturation");

    random_events = 1'b1;
    random_ready  = 1'b1;
    for (int i = 0; i < 80; i++) begin
      send_request(counter_address($urandom_range(0, num_counters - 1)),
                   ($urandom_range(0, 3) == 0));
    end
    idle_bus();
    random_ready  = 1'b0;
    random_events = 1'b0;
    wait_drained();
    // No response may remain once every request has been answered
    tick();
    check_value(perf_word_t'(rsp_valid), 16'h0000, "rsp_valid after draining", main_errors);
    finish_test("back_pressure");

    // Store lands on an edge where the same event is high
    event_hold = perf_event_t'(1) << dl1_miss;
    tick();
    send_request(counter_address(dl1_miss), 1'b1);
    event_hold = '0;
    send_request(counter_address(dl1_miss), 1'b0);
    send_request(counter_address(dl1_miss), 1'b0);
    idle_bus();
    wait_drained();
    check_value(last_rsp_data, 16'h0001, "counter after clear against event", main_errors);
    finish_test("clear_vs_event");

    $display("requests %0d, responses %0d, errors %0d", req_count, rsp_count,
             main_errors + cmp_errors);
    if (main_errors + cmp_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_perf_counter_unit

`default_nettype wire
